// ==== compile.f ====
+incdir+include
rtl/bus_pkg.sv
rtl/mod_pkg.sv
rtl/mem_port_if.sv
rtl/cpu_bus_bridge.sv
rtl/mod_ram.sv
rtl/mod_mem_arbiter.sv
rtl/mod_playback.sv
rtl/mod_bus_top.sv
test/cpu_bus_driver.sv
test/tb_mod_bus.sv

// ==== include/mod_bus_params.svh ====
/*
 * Modulation bus parameters.
 * Controller register map, control bits, RAM geometry and reset values.
 */

`ifndef MOD_BUS_PARAMS_SVH
`define MOD_BUS_PARAMS_SVH

`define ADDR_CTL_REG        14'd0
`define ADDR_MOD_CYCLE      14'd1
`define ADDR_MOD_FREQ_DIV   14'd2

`define CTL_REG_ENABLE_BIT  0

`define MOD_ADDR_WIDTH      10

`define MOD_CYCLE_RESET     16'd255
`define MOD_FREQ_DIV_RESET  16'd40

`endif

// ==== rtl/bus_pkg.sv ====
/*
 * CPU bus package.
 * Bank-select codes and the word and address types of the CPU bus.
 */

package bus_pkg;

    // codes 2 and 3 are reserved banks.
    typedef enum logic [1:0] {
        BRAM_SELECT_CONTROLLER = 2'd0,
        BRAM_SELECT_MOD        = 2'd1,
        BRAM_SELECT_RSVD_2     = 2'd2,
        BRAM_SELECT_RSVD_3     = 2'd3
    } bram_select_e;

    typedef logic [15:0] bus_word_t;

    typedef logic [13:0] bus_addr_t;

endpackage

// ==== rtl/cpu_bus_bridge.sv ====
/*
 * CPU bus bridge.
 * Samples the chip-select bus, holds the controller registers and forwards
 * modulation bank accesses to the RAM arbiter.
 */

`include "mod_bus_params.svh"

module cpu_bus_bridge (
    input  logic                 CPU_CKIO,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 we,
    input  bus_pkg::bram_select_e bram_select,
    input  bus_pkg::bus_addr_t   addr,
    input  bus_pkg::bus_word_t   data_in,
    output bus_pkg::bus_word_t   data_out,
    output logic                 rdata_valid,
    output logic                 ctl_enable,
    output logic [15:0]          mod_cycle,
    output logic [15:0]          mod_freq_div,
    mem_port_if.requester        mem
);

    logic                  en_q, en_qq, we_q, we_qq;
    bus_pkg::bram_select_e sel_q;
    bus_pkg::bus_addr_t    addr_q;
    bus_pkg::bus_word_t    data_q;
    logic [15:0]           ctl_reg;
    bus_pkg::bus_word_t    ctl_rdata;
    logic                  write_start, read_start;

    // a write fires once per access, whether we comes with en or later.
    assign write_start = en_q & we_q & ~(en_qq & we_qq);
    assign read_start  = en_q & ~en_qq & ~we_q;

    assign ctl_enable = ctl_reg[`CTL_REG_ENABLE_BIT];

    always_comb begin
        case (addr_q)
            `ADDR_CTL_REG:      ctl_rdata = ctl_reg;
            `ADDR_MOD_CYCLE:    ctl_rdata = mod_cycle;
            `ADDR_MOD_FREQ_DIV: ctl_rdata = mod_freq_div;
            default:            ctl_rdata = '0;
        endcase
    end

    always_ff @(posedge CPU_CKIO) begin
        sel_q  <= bram_select;
        addr_q <= addr;
        data_q <= data_in;
        if ((read_start || write_start) && sel_q == bus_pkg::BRAM_SELECT_MOD) begin
            mem.we    <= write_start;
            mem.addr  <= addr_q[`MOD_ADDR_WIDTH-1:0];
            mem.wdata <= data_q;
        end
        if (mem.rvalid) begin
            data_out <= mem.rdata;
        end else if (read_start) begin
            data_out <= (sel_q == bus_pkg::BRAM_SELECT_CONTROLLER) ? ctl_rdata : '0;
        end
    end

    always_ff @(posedge CPU_CKIO or negedge rst_n) begin
        if (!rst_n) begin
            en_q         <= 1'b0;
            en_qq        <= 1'b0;
            we_q         <= 1'b0;
            we_qq        <= 1'b0;
            ctl_reg      <= '0;
            mod_cycle    <= `MOD_CYCLE_RESET;
            mod_freq_div <= `MOD_FREQ_DIV_RESET;
            mem.req      <= 1'b0;
            rdata_valid  <= 1'b0;
        end else begin
            en_q  <= en;
            en_qq <= en_q;
            we_q  <= we;
            we_qq <= we_q;
            rdata_valid <= mem.rvalid | (read_start && sel_q != bus_pkg::BRAM_SELECT_MOD);
            if (write_start && sel_q == bus_pkg::BRAM_SELECT_CONTROLLER) begin
                case (addr_q)
                    `ADDR_CTL_REG:      ctl_reg      <= data_q;
                    `ADDR_MOD_CYCLE:    mod_cycle    <= data_q;
                    `ADDR_MOD_FREQ_DIV: mod_freq_div <= data_q;
                    default:            ;
                endcase
            end
            if ((read_start || write_start) && sel_q == bus_pkg::BRAM_SELECT_MOD) begin
                mem.req <= 1'b1;
            end else if (mem.ready) begin
                mem.req <= 1'b0;
            end
        end
    end

    // the host spaces its accesses, so a RAM request is always granted first.
    assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
        (read_start || write_start) |-> !mem.req)
        else $error("bus access started while a RAM request was pending");

endmodule

// ==== rtl/mem_port_if.sv ====
/*
 * Memory port between a requester and the modulation RAM arbiter.
 * A transfer happens when req and ready are both high; rvalid follows a read by one cycle.
 */

`include "mod_bus_params.svh"

interface mem_port_if;

    logic                       req;
    logic                       we;
    logic [`MOD_ADDR_WIDTH-1:0] addr;
    bus_pkg::bus_word_t         wdata;
    logic                       ready;
    bus_pkg::bus_word_t         rdata;
    logic                       rvalid;

    modport requester (
        output req, we, addr, wdata,
        input  ready, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output ready, rdata, rvalid
    );

endinterface

// ==== rtl/mod_bus_top.sv ====
/*
 * Modulation bus subsystem top level.
 * Connects the CPU bus bridge and playback engine to the shared RAM arbiter.
 */

module mod_bus_top (
    input  logic                 CPU_CKIO,
    input  logic                 rst_n,
    input  logic                 cpu_en,
    input  logic                 cpu_we,
    input  logic [1:0]           cpu_bram_select,
    input  bus_pkg::bus_addr_t   cpu_bram_addr,
    input  bus_pkg::bus_word_t   cpu_data_in,
    output bus_pkg::bus_word_t   cpu_data_out,
    output logic                 cpu_rdata_valid,
    output mod_pkg::mod_sample_t mod_sample,
    output logic                 mod_valid,
    input  logic                 mod_ready
);

    logic        ctl_enable;
    logic [15:0] mod_cycle;
    logic [15:0] mod_freq_div;

    mem_port_if port_cpu ();
    mem_port_if port_play ();

    cpu_bus_bridge u_cpu_bus_bridge (
        .CPU_CKIO    (CPU_CKIO),
        .rst_n       (rst_n),
        .en          (cpu_en),
        .we          (cpu_we),
        .bram_select (bus_pkg::bram_select_e'(cpu_bram_select)),
        .addr        (cpu_bram_addr),
        .data_in     (cpu_data_in),
        .data_out    (cpu_data_out),
        .rdata_valid (cpu_rdata_valid),
        .ctl_enable  (ctl_enable),
        .mod_cycle   (mod_cycle),
        .mod_freq_div(mod_freq_div),
        .mem         (port_cpu.requester)
    );

    mod_playback u_mod_playback (
        .CPU_CKIO    (CPU_CKIO),
        .rst_n       (rst_n),
        .enable      (ctl_enable),
        .mod_cycle   (mod_cycle),
        .mod_freq_div(mod_freq_div),
        .mem         (port_play.requester),
        .sample      (mod_sample),
        .sample_valid(mod_valid),
        .sample_ready(mod_ready)
    );

    mod_mem_arbiter u_mod_mem_arbiter (
        .CPU_CKIO (CPU_CKIO),
        .rst_n    (rst_n),
        .port_cpu (port_cpu.arbiter),
        .port_play(port_play.arbiter)
    );

endmodule

// ==== rtl/mod_mem_arbiter.sv ====
/*
 * Modulation RAM arbiter.
 * Round-robin grant between the CPU and playback ports, owning the RAM.
 */

`include "mod_bus_params.svh"

module mod_mem_arbiter (
    input  logic        CPU_CKIO,
    input  logic        rst_n,
    mem_port_if.arbiter port_cpu,
    mem_port_if.arbiter port_play
);

    logic                       grant_cpu, grant_play;
    logic                       last_play;
    logic                       rd_cpu_q, rd_play_q;
    logic                       ram_en, ram_we;
    logic [`MOD_ADDR_WIDTH-1:0] ram_addr;
    bus_pkg::bus_word_t         ram_wdata, ram_rdata;

    // on a tie the port that lost last time wins.
    assign grant_cpu  = port_cpu.req & (~port_play.req | last_play);
    assign grant_play = port_play.req & ~grant_cpu;

    assign port_cpu.ready  = grant_cpu;
    assign port_play.ready = grant_play;

    assign ram_en    = grant_cpu | grant_play;
    assign ram_we    = grant_cpu ? port_cpu.we    : port_play.we;
    assign ram_addr  = grant_cpu ? port_cpu.addr  : port_play.addr;
    assign ram_wdata = grant_cpu ? port_cpu.wdata : port_play.wdata;

    assign port_cpu.rdata   = ram_rdata;
    assign port_play.rdata  = ram_rdata;
    assign port_cpu.rvalid  = rd_cpu_q;
    assign port_play.rvalid = rd_play_q;

    always_ff @(posedge CPU_CKIO or negedge rst_n) begin
        if (!rst_n) begin
            last_play <= 1'b0;
            rd_cpu_q  <= 1'b0;
            rd_play_q <= 1'b0;
        end else begin
            rd_cpu_q  <= grant_cpu & ~port_cpu.we;
            rd_play_q <= grant_play & ~port_play.we;
            if (ram_en) begin
                last_play <= grant_play;
            end
        end
    end

    mod_ram u_mod_ram (
        .CPU_CKIO(CPU_CKIO),
        .en      (ram_en),
        .we      (ram_we),
        .addr    (ram_addr),
        .wdata   (ram_wdata),
        .rdata   (ram_rdata)
    );

    assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
        !(port_cpu.ready && port_play.ready))
        else $error("both memory ports granted in one cycle");

    assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
        port_cpu.rvalid |-> $past(port_cpu.req && port_cpu.ready && !port_cpu.we))
        else $error("cpu rvalid without a granted read");

    assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
        port_play.rvalid |-> $past(port_play.req && port_play.ready && !port_play.we))
        else $error("playback rvalid without a granted read");

endmodule

// ==== rtl/mod_pkg.sv ====
/*
 * Modulation package.
 * Sample, sample index and playback state types.
 */

package mod_pkg;

    typedef logic [7:0] mod_sample_t;

    // sample index, counts bytes of the modulation RAM.
    typedef logic [15:0] mod_index_t;

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_TICK = 2'd1,
        FETCH     = 2'd2,
        HOLD      = 2'd3
    } playback_state_e;

endpackage

// ==== rtl/mod_playback.sv ====
/*
 * Modulation playback engine.
 * A tick timer paces fetches of amplitude samples from the modulation RAM,
 * which leave one at a time on a valid/ready output.
 */

`include "mod_bus_params.svh"

module mod_playback (
    input  logic                CPU_CKIO,
    input  logic                rst_n,
    input  logic                enable,
    input  logic [15:0]         mod_cycle,
    input  logic [15:0]         mod_freq_div,
    mem_port_if.requester       mem,
    output mod_pkg::mod_sample_t sample,
    output logic                sample_valid,
    input  logic                sample_ready
);

    mod_pkg::playback_state_e state;
    mod_pkg::mod_index_t      index;
    logic [15:0]              tick_cnt;
    logic                     tick;
    logic                     byte_sel;

    // the engine only reads.
    assign mem.we    = 1'b0;
    assign mem.wdata = '0;

    // a divider of 1 ticks every cycle.
    assign tick = enable && ({1'b0, tick_cnt} + 17'd1 >= {1'b0, mod_freq_div});

    always_ff @(posedge CPU_CKIO) begin
        if (state == mod_pkg::WAIT_TICK && tick) begin
            mem.addr <= index[`MOD_ADDR_WIDTH:1];
            byte_sel <= index[0];
        end
        if (state == mod_pkg::FETCH && mem.rvalid) begin
            sample <= byte_sel ? mem.rdata[15:8] : mem.rdata[7:0];
        end
    end

    always_ff @(posedge CPU_CKIO or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt     <= '0;
            state        <= mod_pkg::IDLE;
            index        <= '0;
            mem.req      <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            tick_cnt <= (!enable || tick) ? '0 : tick_cnt + 16'd1;
            case (state)
                mod_pkg::IDLE: begin
                    index <= '0;
                    if (enable) begin
                        state <= mod_pkg::WAIT_TICK;
                    end
                end
                mod_pkg::WAIT_TICK: begin
                    if (!enable) begin
                        state <= mod_pkg::IDLE;
                    end else if (tick) begin
                        mem.req <= 1'b1;
                        state   <= mod_pkg::FETCH;
                    end
                end
                mod_pkg::FETCH: begin
                    if (mem.ready) begin
                        mem.req <= 1'b0;
                    end
                    if (mem.rvalid) begin
                        sample_valid <= 1'b1;
                        state        <= mod_pkg::HOLD;
                    end
                end
                mod_pkg::HOLD: begin
                    // ticks are ignored here, so back-pressure never drops a sample.
                    if (sample_ready) begin
                        sample_valid <= 1'b0;
                        index        <= (index == mod_cycle) ? '0 : index + 16'd1;
                        state        <= enable ? mod_pkg::WAIT_TICK : mod_pkg::IDLE;
                    end
                end
                default: state <= mod_pkg::IDLE;
            endcase
        end
    end

    assert property (@(posedge CPU_CKIO) disable iff (!rst_n)
        (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample)))
        else $error("sample changed or dropped before it was accepted");

endmodule

// ==== rtl/mod_ram.sv ====
/*
 * Modulation RAM.
 * Single-port block RAM of 16-bit words with a registered read.
 */

`include "mod_bus_params.svh"

module mod_ram (
    input  logic                       CPU_CKIO,
    input  logic                       en,
    input  logic                       we,
    input  logic [`MOD_ADDR_WIDTH-1:0] addr,
    input  bus_pkg::bus_word_t         wdata,
    output bus_pkg::bus_word_t         rdata
);

    bus_pkg::bus_word_t mem [0:(1 << `MOD_ADDR_WIDTH)-1];

    always_ff @(posedge CPU_CKIO) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// ==== test/cpu_bus_driver.sv ====
/*
 * CPU bus driver.
 * Bus-functional model of the host side of the chip-select bus, driven on the falling edge.
 */

module cpu_bus_driver (
    input  logic               CPU_CKIO,
    output logic               en,
    output logic               we,
    output logic [1:0]         bram_select,
    output bus_pkg::bus_addr_t addr,
    output bus_pkg::bus_word_t data_in,
    input  bus_pkg::bus_word_t data_out,
    input  logic               rdata_valid
);

    localparam int ACCESS_GAP   = 8;
    localparam int READ_TIMEOUT = 64;

    initial begin
        en          = 1'b0;
        we          = 1'b0;
        bram_select = 2'd0;
        addr        = '0;
        data_in     = '0;
    end

    // the bus has no wait signal, so every access is preceded by idle cycles.
    task automatic bus_write(input logic [1:0] sel, input bus_pkg::bus_addr_t a,
                             input bus_pkg::bus_word_t d);
        repeat (ACCESS_GAP) @(negedge CPU_CKIO);
        bram_select = sel;
        addr        = a;
        data_in     = d;
        en          = 1'b1;
        we          = 1'b1;
        repeat (2) @(negedge CPU_CKIO);
        en = 1'b0;
        we = 1'b0;
    endtask

    // latency counts falling edges from the start of the access, or is -1 on a timeout.
    task automatic bus_read(input logic [1:0] sel, input bus_pkg::bus_addr_t a,
                            output bus_pkg::bus_word_t d, output int latency);
        repeat (ACCESS_GAP) @(negedge CPU_CKIO);
        bram_select = sel;
        addr        = a;
        en          = 1'b1;
        we          = 1'b0;
        d           = '0;
        latency     = -1;
        for (int n = 1; n <= READ_TIMEOUT && latency < 0; n++) begin
            @(negedge CPU_CKIO);
            if (rdata_valid) begin
                latency = n;
                d       = data_out;
            end
        end
        en = 1'b0;
    endtask

endmodule

// ==== test/tb_mod_bus.sv ====
/*
 * Testbench for the modulation bus subsystem.
 * Random bus traffic and playback under random back-pressure, checked against a model.
 */

`include "mod_bus_params.svh"

module tb_mod_bus;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int SAMPLE_TIMEOUT = 20000;
    localparam int IDLE_TIMEOUT   = 500;
    localparam int WATCHDOG       = 200000;

    logic                 CPU_CKIO;
    logic                 rst_n;
    logic                 cpu_en;
    logic                 cpu_we;
    logic [1:0]           cpu_bram_select;
    bus_pkg::bus_addr_t   cpu_bram_addr;
    bus_pkg::bus_word_t   cpu_data_in;
    bus_pkg::bus_word_t   cpu_data_out;
    logic                 cpu_rdata_valid;
    mod_pkg::mod_sample_t mod_sample;
    logic                 mod_valid;
    logic                 mod_ready;

    integer               stim_seed;
    integer               ready_seed = 4718;
    int                   check_errors;
    int                   timeout_errors;
    int                   accepted;
    int                   snapshot;
    int                   i;
    bus_pkg::bus_addr_t   a;
    bus_pkg::bus_word_t   d;
    bus_pkg::bus_word_t   shadow_ctl [0:2];
    bus_pkg::bus_word_t   shadow_ram [0:(1 << `MOD_ADDR_WIDTH)-1];
    bus_pkg::bus_addr_t   written_addrs [$];
    mod_pkg::mod_sample_t exp_q [$];
    mod_pkg::mod_sample_t next_sample;

    mod_bus_top UUT (
        .CPU_CKIO       (CPU_CKIO),
        .rst_n          (rst_n),
        .cpu_en         (cpu_en),
        .cpu_we         (cpu_we),
        .cpu_bram_select(cpu_bram_select),
        .cpu_bram_addr  (cpu_bram_addr),
        .cpu_data_in    (cpu_data_in),
        .cpu_data_out   (cpu_data_out),
        .cpu_rdata_valid(cpu_rdata_valid),
        .mod_sample     (mod_sample),
        .mod_valid      (mod_valid),
        .mod_ready      (mod_ready)
    );

    cpu_bus_driver u_bus_driver (
        .CPU_CKIO   (CPU_CKIO),
        .en         (cpu_en),
        .we         (cpu_we),
        .bram_select(cpu_bram_select),
        .addr       (cpu_bram_addr),
        .data_in    (cpu_data_in),
        .data_out   (cpu_data_out),
        .rdata_valid(cpu_rdata_valid)
    );

    initial begin
        CPU_CKIO = 1'b0;
        forever #(CLK_PERIOD / 2) CPU_CKIO = ~CPU_CKIO;
    end

    task automatic check_word(input string name, input bus_pkg::bus_word_t exp,
                              input bus_pkg::bus_word_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_sample(input string name, input mod_pkg::mod_sample_t exp,
                                input mod_pkg::mod_sample_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            check_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int lo, input int hi, input int act);
        if (act < lo || act > hi) begin
            $display("CHECK FAILED %s latency expected %0d to %0d actual %0d", name, lo, hi, act);
            check_errors++;
        end
    endtask

    task automatic write_ctl(input bus_pkg::bus_addr_t addr, input bus_pkg::bus_word_t data);
        shadow_ctl[addr] = data;
        u_bus_driver.bus_write(bus_pkg::BRAM_SELECT_CONTROLLER, addr, data);
    endtask

    task automatic write_ram(input bus_pkg::bus_addr_t addr, input bus_pkg::bus_word_t data);
        shadow_ram[addr[`MOD_ADDR_WIDTH-1:0]] = data;
        u_bus_driver.bus_write(bus_pkg::BRAM_SELECT_MOD, addr, data);
    endtask

    task automatic read_and_compare(input string name, input logic [1:0] sel,
                                    input bus_pkg::bus_addr_t addr, input bus_pkg::bus_word_t exp,
                                    input int lo, input int hi);
        bus_pkg::bus_word_t data;
        int                 latency;
        u_bus_driver.bus_read(sel, addr, data, latency);
        if (latency < 0) begin
            $display("read of %s never returned cpu_rdata_valid", name);
            timeout_errors++;
        end else begin
            check_word(name, exp, data);
            check_latency(name, lo, hi, latency);
        end
    endtask

    // one period of samples, bytes of the RAM low byte first, from index 0 to mod_cycle.
    task automatic load_expected();
        bus_pkg::bus_word_t w;
        exp_q.delete();
        for (int n = 0; n <= shadow_ctl[`ADDR_MOD_CYCLE]; n++) begin
            w = shadow_ram[n >> 1];
            exp_q.push_back(n[0] ? w[15:8] : w[7:0]);
        end
    endtask

    task automatic wait_samples(input int count);
        int target;
        int n;
        target = accepted + count;
        n      = 0;
        while (accepted < target && n < SAMPLE_TIMEOUT) begin
            @(negedge CPU_CKIO);
            n++;
        end
        if (accepted < target) begin
            $display("timed out waiting for %0d playback samples", count);
            timeout_errors++;
        end
    endtask

    task automatic wait_playback_idle();
        int quiet;
        int n;
        quiet = 0;
        n     = 0;
        while (quiet < 10 && n < IDLE_TIMEOUT) begin
            @(negedge CPU_CKIO);
            n++;
            quiet = mod_valid ? 0 : quiet + 1;
        end
        if (quiet < 10) begin
            $display("playback did not go idle after the enable bit was cleared");
            timeout_errors++;
        end
    endtask

    // mod_ready is redrawn first, so the check sees the handshake of the next rising edge.
    always @(negedge CPU_CKIO) begin
        mod_ready = ($random(ready_seed) & 1) != 0;
        if (rst_n && mod_valid && mod_ready) begin
            accepted++;
            if (exp_q.size() == 0) begin
                $display("a playback sample was accepted while none was expected");
                check_errors++;
            end else begin
                next_sample = exp_q.pop_front();
                exp_q.push_back(next_sample);
                check_sample("playback sample", next_sample, mod_sample);
            end
        end
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG);
        $display("simulation ran past the watchdog limit");
        $display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        stim_seed      = 4718;
        check_errors   = 0;
        timeout_errors = 0;
        accepted       = 0;
        rst_n          = 1'b0;
        mod_ready      = 1'b0;
        shadow_ctl[`ADDR_CTL_REG]      = '0;
        shadow_ctl[`ADDR_MOD_CYCLE]    = `MOD_CYCLE_RESET;
        shadow_ctl[`ADDR_MOD_FREQ_DIV] = `MOD_FREQ_DIV_RESET;
        repeat (RESET_CYCLES) @(posedge CPU_CKIO);
        @(negedge CPU_CKIO);
        rst_n = 1'b1;
        check_word("valid outputs after reset", 16'h0, {14'b0, mod_valid, cpu_rdata_valid});
        for (i = 0; i < 3; i++) begin
            read_and_compare($sformatf("reset value of register %0d", i),
                             bus_pkg::BRAM_SELECT_CONTROLLER, i, shadow_ctl[i], 2, 2);
        end

        // controller registers, with playback kept disabled.
        for (i = 0; i < 3; i++) begin
            d = bus_pkg::bus_word_t'($random(stim_seed));
            if (i == `ADDR_CTL_REG) begin
                d[`CTL_REG_ENABLE_BIT] = 1'b0;
            end
            write_ctl(i, d);
            read_and_compare($sformatf("controller register %0d", i),
                             bus_pkg::BRAM_SELECT_CONTROLLER, i, shadow_ctl[i], 2, 2);
        end

        // random modulation RAM words.
        repeat (12) begin
            a = bus_pkg::bus_addr_t'($random(stim_seed) & ((1 << `MOD_ADDR_WIDTH) - 1));
            write_ram(a, bus_pkg::bus_word_t'($random(stim_seed)));
            written_addrs.push_back(a);
        end
        foreach (written_addrs[k]) begin
            read_and_compare($sformatf("ram word %h", written_addrs[k]), bus_pkg::BRAM_SELECT_MOD,
                             written_addrs[k], shadow_ram[written_addrs[k]], 3, 32);
        end

        // playback of a random table under random back-pressure.
        write_ctl(`ADDR_MOD_CYCLE, 16'd8 + bus_pkg::bus_word_t'($random(stim_seed) & 31));
        write_ctl(`ADDR_MOD_FREQ_DIV, 16'd1 + bus_pkg::bus_word_t'($random(stim_seed) & 7));
        for (i = 0; i <= shadow_ctl[`ADDR_MOD_CYCLE] / 2; i++) begin
            write_ram(i, bus_pkg::bus_word_t'($random(stim_seed)));
        end
        load_expected();
        write_ctl(`ADDR_CTL_REG, 16'd1 << `CTL_REG_ENABLE_BIT);
        wait_samples(2 * (shadow_ctl[`ADDR_MOD_CYCLE] + 1) + 3);

        // CPU reads contend with playback for the RAM.
        repeat (6) begin
            a = bus_pkg::bus_addr_t'($unsigned($random(stim_seed))
                                     % (shadow_ctl[`ADDR_MOD_CYCLE] / 2 + 1));
            read_and_compare($sformatf("ram word %h during playback", a),
                             bus_pkg::BRAM_SELECT_MOD, a, shadow_ram[a], 3, 32);
            i = $unsigned($random(stim_seed)) % 3;
            read_and_compare($sformatf("register %0d during playback", i),
                             bus_pkg::BRAM_SELECT_CONTROLLER, i, shadow_ctl[i], 2, 2);
        end
        wait_samples(shadow_ctl[`ADDR_MOD_CYCLE] + 5);

        // disable, then restart from index 0.
        write_ctl(`ADDR_CTL_REG, 16'd0);
        snapshot = accepted;
        wait_playback_idle();
        if (accepted - snapshot > 1) begin
            $display("%0d samples were accepted after playback was disabled",
                     accepted - snapshot);
            check_errors++;
        end
        load_expected();
        write_ctl(`ADDR_CTL_REG, 16'd1 << `CTL_REG_ENABLE_BIT);
        wait_samples(shadow_ctl[`ADDR_MOD_CYCLE] + 3);
        write_ctl(`ADDR_CTL_REG, 16'd0);
        wait_playback_idle();

        // reserved banks ignore writes and read as zero.
        u_bus_driver.bus_write(bus_pkg::BRAM_SELECT_RSVD_2, `ADDR_MOD_CYCLE,
                               ~shadow_ctl[`ADDR_MOD_CYCLE]);
        u_bus_driver.bus_write(bus_pkg::BRAM_SELECT_RSVD_3, `ADDR_CTL_REG,
                               16'd1 << `CTL_REG_ENABLE_BIT);
        u_bus_driver.bus_write(bus_pkg::BRAM_SELECT_RSVD_2, written_addrs[0],
                               ~shadow_ram[written_addrs[0]]);
        for (i = 0; i < 3; i++) begin
            read_and_compare($sformatf("register %0d after reserved writes", i),
                             bus_pkg::BRAM_SELECT_CONTROLLER, i, shadow_ctl[i], 2, 2);
        end
        read_and_compare("ram word after reserved writes", bus_pkg::BRAM_SELECT_MOD,
                         written_addrs[0], shadow_ram[written_addrs[0]], 3, 32);
        read_and_compare("reserved bank 2 read", bus_pkg::BRAM_SELECT_RSVD_2,
                         `ADDR_MOD_CYCLE, 16'h0, 2, 2);
        read_and_compare("reserved bank 3 read", bus_pkg::BRAM_SELECT_RSVD_3,
                         written_addrs[0], 16'h0, 2, 2);

        $display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
